// File: common/mcsr_settings.svh
`ifndef MCSR_SETTINGS_SVH
`define MCSR_SETTINGS_SVH

// widths
`define MCSR_DATA_WIDTH		32
`define MCSR_INSTR_WIDTH	32
`define MCSR_ADDR_WIDTH		12

// csr addresses, machine level
`define MVENDORID		12'hF11
`define MARCHID			12'hF12
`define MIMPID			12'hF13
`define MHARTID			12'hF14
`define MSTATUS			12'h300
`define MISA			12'h301
`define MIE			12'h304
`define MTVEC			12'h305
`define MEPC			12'h341
`define MCAUSE			12'h342
`define MTVAL			12'h343
`define MIP			12'h344
`define TCM_CTRL		12'h7C0		// custom, tcm enable
`define DTCM_START_ADDR		12'h7C1		// custom, dtcm base

// reset and id values
`define MCSR_VECTOR_ENTRY	32'h0000_0100
`define MCSR_DTCM_START		32'h0008_0000
`define MCSR_MIMPID_VALUE	32'h1000_0000
`define MCSR_MISA_RESET		26'h000_0100	// I extension only

// one-hot select positions
`define MCSR_N			14
`define MCSR_SEL_MVENDORID	0
`define MCSR_SEL_MARCHID	1
`define MCSR_SEL_MIMPID		2
`define MCSR_SEL_MHARTID	3
`define MCSR_SEL_MSTATUS	4
`define MCSR_SEL_MISA		5
`define MCSR_SEL_MIE		6
`define MCSR_SEL_MTVEC		7
`define MCSR_SEL_MEPC		8
`define MCSR_SEL_MCAUSE		9
`define MCSR_SEL_MTVAL		10
`define MCSR_SEL_MIP		11
`define MCSR_SEL_TCM_CTRL	12
`define MCSR_SEL_DTCM_START_ADDR	13

`endif

// File: common/mcsr_pkg.sv
`default_nettype none

`include "mcsr_settings.svh"

package mcsr_pkg;

	typedef logic [`MCSR_DATA_WIDTH-1:0]	csr_data_t;	// csr data word
	typedef logic [`MCSR_ADDR_WIDTH-1:0]	csr_addr_t;	// csr address
	typedef logic [`MCSR_INSTR_WIDTH-1:0]	instr_t;	// raw instruction
	typedef logic [`MCSR_N-1:0]		csr_sel_t;	// one bit per implemented csr
	typedef logic [25:0]			misa_ext_t;	// misa extension bits

	// new register word from old word and write data
	// set wins over clear, plain write otherwise
	function automatic csr_data_t csr_merge(
		input csr_data_t	old_val,
		input csr_data_t	wr_val,
		input logic		set,
		input logic		clr
	);
		if (set)
		begin
			return old_val | wr_val;
		end
		else if (clr)
		begin
			return old_val & ~wr_val;
		end
		else
		begin
			return wr_val;
		end
	endfunction

endpackage

`default_nettype wire

// File: mcsr/csr_decode.sv
`default_nettype none
`timescale 1ns/1ns

`include "mcsr_settings.svh"

module csr_decode (
	input  wire mcsr_pkg::csr_addr_t	csr_addr,		// from decode
	input  wire mcsr_pkg::instr_t		instr_dec,		// instr under decode
	input  wire				mcsr_rd,		// instr reads a csr
	input  wire				mcsr_wr,		// instr writes a csr
	input  wire				valid_mcsr_rd,		// read commit strobe
	input  wire				valid_mcsr_wr,		// write commit strobe
	output mcsr_pkg::csr_sel_t		addr_sel,		// raw address match
	output mcsr_pkg::csr_sel_t		wr_en,			// committed write
	output mcsr_pkg::csr_sel_t		rd_en,			// committed read
	output logic				csr_illegal_access,
	output mcsr_pkg::instr_t		illegal_instr
);

	logic	ro_sel;		// one of the id regs
	logic	no_csr_hit;	// address not implemented
	logic	ro_write;	// write to read-only

	// compare against every implemented address
	always_comb
	begin
		addr_sel = '0;
		addr_sel[`MCSR_SEL_MVENDORID]		= (csr_addr == `MVENDORID);
		addr_sel[`MCSR_SEL_MARCHID]		= (csr_addr == `MARCHID);
		addr_sel[`MCSR_SEL_MIMPID]		= (csr_addr == `MIMPID);
		addr_sel[`MCSR_SEL_MHARTID]		= (csr_addr == `MHARTID);
		addr_sel[`MCSR_SEL_MSTATUS]		= (csr_addr == `MSTATUS);
		addr_sel[`MCSR_SEL_MISA]		= (csr_addr == `MISA);
		addr_sel[`MCSR_SEL_MIE]			= (csr_addr == `MIE);
		addr_sel[`MCSR_SEL_MTVEC]		= (csr_addr == `MTVEC);
		addr_sel[`MCSR_SEL_MEPC]		= (csr_addr == `MEPC);
		addr_sel[`MCSR_SEL_MCAUSE]		= (csr_addr == `MCAUSE);
		addr_sel[`MCSR_SEL_MTVAL]		= (csr_addr == `MTVAL);
		addr_sel[`MCSR_SEL_MIP]			= (csr_addr == `MIP);
		addr_sel[`MCSR_SEL_TCM_CTRL]		= (csr_addr == `TCM_CTRL);
		addr_sel[`MCSR_SEL_DTCM_START_ADDR]	= (csr_addr == `DTCM_START_ADDR);
	end

	assign ro_sel = addr_sel[`MCSR_SEL_MVENDORID] | addr_sel[`MCSR_SEL_MARCHID] |
			addr_sel[`MCSR_SEL_MIMPID] | addr_sel[`MCSR_SEL_MHARTID];

	// old dummy regs land here too
	assign no_csr_hit = (mcsr_rd | mcsr_wr) & ~(|addr_sel);
	assign ro_write = ro_sel & mcsr_wr;

	assign csr_illegal_access = no_csr_hit | ro_write;
	assign illegal_instr = csr_illegal_access ? instr_dec : '0;	// for mtval capture

	// select is one-hot, so ro_sel masks only the id bit
	assign wr_en = addr_sel & {`MCSR_N{valid_mcsr_wr & ~ro_sel}};
	assign rd_en = addr_sel & {`MCSR_N{valid_mcsr_rd}};

endmodule

`default_nettype wire

// File: mcsr/mstatus_trap.sv
`default_nettype none
`timescale 1ns/1ns

module mstatus_trap (
	input  wire				cpu_clk,
	input  wire				cpu_rstn,
	input  wire				wr_en,			// mstatus write commit
	input  wire				mcsr_set,
	input  wire				mcsr_clr,
	input  wire mcsr_pkg::csr_data_t	write_data,
	input  wire				valid_interrupt,	// trap taken
	input  wire				mret,			// trap return
	output logic				mstatus_mie,		// global irq enable
	output logic				mstatus_mpie		// saved mie
);

	import mcsr_pkg::*;

	logic		int_active;	// inside an interrupt handler
	csr_data_t	merged;		// mstatus after csr write

	// interrupt in progress flag
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			int_active <= 1'b0;
		end
		else if (mret)
		begin
			int_active <= 1'b0;
		end
		else if (valid_interrupt)
		begin
			int_active <= 1'b1;
		end
	end

	// only mpie bit 7 and mie bit 3 are kept
	assign merged = csr_merge({24'h0, mstatus_mpie, 3'h0, mstatus_mie, 3'h0},
				  write_data, mcsr_set, mcsr_clr);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
		end
		else if (mret && int_active)
		begin
			mstatus_mie <= mstatus_mpie;	// restore on return
			mstatus_mpie <= 1'b1;
		end
		else if (valid_interrupt)
		begin
			mstatus_mpie <= mstatus_mie;	// save
			mstatus_mie <= 1'b0;		// block nesting
		end
		else if (wr_en)
		begin
			mstatus_mie <= merged[3];
			mstatus_mpie <= merged[7];
		end
	end

endmodule

`default_nettype wire

// File: mcsr/csr_config_regs.sv
`default_nettype none
`timescale 1ns/1ns

`include "mcsr_settings.svh"

module csr_config_regs (
	input  wire				cpu_clk,
	input  wire				cpu_rstn,
	input  wire mcsr_pkg::csr_sel_t		wr_en,			// committed write, one-hot
	input  wire				mcsr_set,
	input  wire				mcsr_clr,
	input  wire mcsr_pkg::csr_data_t	write_data,
	output mcsr_pkg::misa_ext_t		misa_ext,		// misa extensions
	output logic				meie,			// ext irq enable
	output logic				mtie,			// timer irq enable
	output logic				dtcm_en,		// tcm_ctrl bit 0
	output logic [1:0]			mtvec_mode,		// direct or vectored
	output mcsr_pkg::csr_data_t		mtvec_base,		// low 2 bits held 0
	output mcsr_pkg::csr_data_t		dtcm_start_addr
);

	import mcsr_pkg::*;

	csr_data_t	misa_new;
	csr_data_t	mie_new;
	csr_data_t	mtvec_new;
	csr_data_t	tcm_new;
	csr_data_t	dtcm_addr_new;

	// merged words, each in its csr bit layout
	assign misa_new = csr_merge({6'h0, misa_ext}, write_data, mcsr_set, mcsr_clr);
	assign mie_new = csr_merge({20'h0, meie, 3'h0, mtie, 7'h0}, write_data,
				   mcsr_set, mcsr_clr);
	assign mtvec_new = csr_merge({mtvec_base[31:2], mtvec_mode}, write_data,
				     mcsr_set, mcsr_clr);	// whole word, base and mode
	assign tcm_new = csr_merge({31'h0, dtcm_en}, write_data, mcsr_set, mcsr_clr);
	assign dtcm_addr_new = csr_merge(dtcm_start_addr, write_data, mcsr_set, mcsr_clr);

	// misa
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			misa_ext <= `MCSR_MISA_RESET;
		end
		else if (wr_en[`MCSR_SEL_MISA])
		begin
			misa_ext <= misa_new[25:0];	// mxl is fixed, not stored
		end
	end

	// mie, both enables on out of reset
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			meie <= 1'b1;
			mtie <= 1'b1;
		end
		else if (wr_en[`MCSR_SEL_MIE])
		begin
			meie <= mie_new[11];
			mtie <= mie_new[7];
		end
	end

	// mtvec
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			mtvec_mode <= 2'h0;
			mtvec_base <= `MCSR_VECTOR_ENTRY;
		end
		else if (wr_en[`MCSR_SEL_MTVEC])
		begin
			mtvec_mode <= mtvec_new[1:0];
			mtvec_base <= {mtvec_new[31:2], 2'h0};	// word aligned
		end
	end

	// tcm_ctrl
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			dtcm_en <= 1'b1;
		end
		else if (wr_en[`MCSR_SEL_TCM_CTRL])
		begin
			dtcm_en <= tcm_new[0];
		end
	end

	// dtcm base for mem_ctrl
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			dtcm_start_addr <= `MCSR_DTCM_START;
		end
		else if (wr_en[`MCSR_SEL_DTCM_START_ADDR])
		begin
			dtcm_start_addr <= dtcm_addr_new;
		end
	end

endmodule

`default_nettype wire

// File: mcsr/csr_read_mux.sv
`default_nettype none
`timescale 1ns/1ns

`include "mcsr_settings.svh"

module csr_read_mux (
	input  wire mcsr_pkg::csr_sel_t		rd_en,		// committed read, one-hot
	input  wire mcsr_pkg::misa_ext_t	misa_ext,
	input  wire				mstatus_mie,
	input  wire				mstatus_mpie,
	input  wire				meie,
	input  wire				mtie,
	input  wire				meip,		// ext irq pending
	input  wire				mtip,		// timer irq pending
	input  wire [1:0]			mtvec_mode,
	input  wire mcsr_pkg::csr_data_t	mtvec_base,
	input  wire mcsr_pkg::csr_data_t	mepc,		// held in trap_ctrl
	input  wire mcsr_pkg::csr_data_t	mcause,
	input  wire mcsr_pkg::csr_data_t	mtval,
	input  wire				dtcm_en,
	input  wire mcsr_pkg::csr_data_t	dtcm_start_addr,
	output mcsr_pkg::csr_data_t		read_data	// zero when no read
);

	import mcsr_pkg::*;

	csr_data_t	word [`MCSR_N];	// read layout per register

	assign word[`MCSR_SEL_MVENDORID]	= '0;				// non-commercial
	assign word[`MCSR_SEL_MARCHID]		= '0;
	assign word[`MCSR_SEL_MIMPID]		= `MCSR_MIMPID_VALUE;
	assign word[`MCSR_SEL_MHARTID]		= '0;				// single hart
	assign word[`MCSR_SEL_MISA]		= {2'h1, 4'h0, misa_ext};	// rv32
	assign word[`MCSR_SEL_MSTATUS]		= {24'h0, mstatus_mpie, 3'h0, mstatus_mie, 3'h0};
	assign word[`MCSR_SEL_MIE]		= {20'h0, meie, 3'h0, mtie, 7'h0};
	assign word[`MCSR_SEL_MIP]		= {20'h0, meip, 3'h0, mtip, 7'h0};
	assign word[`MCSR_SEL_MTVEC]		= {mtvec_base[31:2], mtvec_mode};
	assign word[`MCSR_SEL_MEPC]		= mepc;
	assign word[`MCSR_SEL_MCAUSE]		= mcause;
	assign word[`MCSR_SEL_MTVAL]		= mtval;
	assign word[`MCSR_SEL_TCM_CTRL]		= {31'h0, dtcm_en};
	assign word[`MCSR_SEL_DTCM_START_ADDR]	= dtcm_start_addr;

	// and-or mux, rd_en already carries valid_mcsr_rd
	always_comb
	begin
		read_data = '0;
		for (int i = 0; i < `MCSR_N; i++)
		begin
			read_data = read_data | (word[i] & {`MCSR_DATA_WIDTH{rd_en[i]}});
		end
	end

endmodule

`default_nettype wire

// File: mcsr/mcsr.sv
`default_nettype none
`timescale 1ns/1ns

`include "mcsr_settings.svh"

module mcsr (
	input  wire				cpu_clk,
	input  wire				cpu_rstn,
	// decode side
	input  wire mcsr_pkg::instr_t		instr_dec,
	input  wire mcsr_pkg::csr_addr_t	csr_addr,
	input  wire				mcsr_rd,
	input  wire				mcsr_wr,
	input  wire				valid_mcsr_rd,
	input  wire				valid_mcsr_wr,
	input  wire				mcsr_set,
	input  wire				mcsr_clr,
	input  wire mcsr_pkg::csr_data_t	write_data,
	output mcsr_pkg::csr_data_t		read_data,
	// trap_ctrl side
	input  wire				meip,
	input  wire				mtip,
	input  wire mcsr_pkg::csr_data_t	mepc,
	input  wire mcsr_pkg::csr_data_t	mcause,
	input  wire mcsr_pkg::csr_data_t	mtval,
	input  wire				valid_interrupt,
	input  wire				mret,
	output logic				mepc_sel,	// address hits, not gated
	output logic				mcause_sel,
	output logic				mtval_sel,
	output logic				csr_illegal_access,
	output mcsr_pkg::instr_t		illegal_instr,
	output logic				meie,
	output logic				mtie,
	output logic				mstatus_mie,
	output logic [1:0]			mtvec_mode,
	output mcsr_pkg::csr_data_t		mtvec_base,
	// mem_ctrl side
	output logic				dtcm_en,
	output mcsr_pkg::csr_data_t		dtcm_start_addr
);

	import mcsr_pkg::*;

	csr_sel_t	addr_sel;
	csr_sel_t	wr_en;
	csr_sel_t	rd_en;
	misa_ext_t	misa_ext;
	logic		mstatus_mpie;	// internal, read only via mstatus

	// trap_ctrl owns these regs, it only needs the selects
	assign mepc_sel = addr_sel[`MCSR_SEL_MEPC];
	assign mcause_sel = addr_sel[`MCSR_SEL_MCAUSE];
	assign mtval_sel = addr_sel[`MCSR_SEL_MTVAL];

	csr_decode u_csr_decode (
		.csr_addr		(csr_addr),
		.instr_dec		(instr_dec),
		.mcsr_rd		(mcsr_rd),
		.mcsr_wr		(mcsr_wr),
		.valid_mcsr_rd		(valid_mcsr_rd),
		.valid_mcsr_wr		(valid_mcsr_wr),
		.addr_sel		(addr_sel),
		.wr_en			(wr_en),
		.rd_en			(rd_en),
		.csr_illegal_access	(csr_illegal_access),
		.illegal_instr		(illegal_instr)
	);

	mstatus_trap u_mstatus_trap (
		.cpu_clk		(cpu_clk),
		.cpu_rstn		(cpu_rstn),
		.wr_en			(wr_en[`MCSR_SEL_MSTATUS]),
		.mcsr_set		(mcsr_set),
		.mcsr_clr		(mcsr_clr),
		.write_data		(write_data),
		.valid_interrupt	(valid_interrupt),
		.mret			(mret),
		.mstatus_mie		(mstatus_mie),
		.mstatus_mpie		(mstatus_mpie)
	);

	csr_config_regs u_csr_config_regs (
		.cpu_clk		(cpu_clk),
		.cpu_rstn		(cpu_rstn),
		.wr_en			(wr_en),
		.mcsr_set		(mcsr_set),
		.mcsr_clr		(mcsr_clr),
		.write_data		(write_data),
		.misa_ext		(misa_ext),
		.meie			(meie),
		.mtie			(mtie),
		.dtcm_en		(dtcm_en),
		.mtvec_mode		(mtvec_mode),
		.mtvec_base		(mtvec_base),
		.dtcm_start_addr	(dtcm_start_addr)
	);

	csr_read_mux u_csr_read_mux (
		.rd_en			(rd_en),
		.misa_ext		(misa_ext),
		.mstatus_mie		(mstatus_mie),
		.mstatus_mpie		(mstatus_mpie),
		.meie			(meie),
		.mtie			(mtie),
		.meip			(meip),
		.mtip			(mtip),
		.mtvec_mode		(mtvec_mode),
		.mtvec_base		(mtvec_base),
		.mepc			(mepc),
		.mcause			(mcause),
		.mtval			(mtval),
		.dtcm_en		(dtcm_en),
		.dtcm_start_addr	(dtcm_start_addr),
		.read_data		(read_data)
	);

endmodule

`default_nettype wire

// File: verification/mcsr_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "mcsr_settings.svh"

module mcsr_tb;

	import mcsr_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 8;
	localparam int WR_ITER = 4;		// random writes per register and mode
	// rough cycle count per test, doubled for the watchdog
	localparam int TEST_CYCLES = RST_CYCLES + 20 + 5 * 4 * WR_ITER * 2 + 20 + 15 + 35;
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

	logic		cpu_clk;
	logic		cpu_rstn;
	instr_t		instr_dec;
	csr_addr_t	csr_addr;
	logic		mcsr_rd;
	logic		mcsr_wr;
	logic		valid_mcsr_rd;
	logic		valid_mcsr_wr;
	logic		mcsr_set;
	logic		mcsr_clr;
	csr_data_t	write_data;
	logic		meip;
	logic		mtip;
	csr_data_t	mepc;
	csr_data_t	mcause;
	csr_data_t	mtval;
	logic		valid_interrupt;
	logic		mret;
	csr_data_t	read_data;
	logic		mepc_sel;
	logic		mcause_sel;
	logic		mtval_sel;
	logic		csr_illegal_access;
	instr_t		illegal_instr;
	logic		meie;
	logic		mtie;
	logic		mstatus_mie;
	logic [1:0]	mtvec_mode;
	csr_data_t	mtvec_base;
	logic		dtcm_en;
	csr_data_t	dtcm_start_addr;

	integer		seed;
	int		errors;
	int		checks;

	// shadow model, each register in its read layout
	logic [31:0]	m_misa;		// extension bits only
	logic [31:0]	m_mstatus;
	logic [31:0]	m_mie;
	logic [31:0]	m_mtvec;
	logic [31:0]	m_tcm;
	logic [31:0]	m_dtcm;
	logic		m_int_active;	// handler entered, no mret yet

	mcsr dut (
		.cpu_clk		(cpu_clk),
		.cpu_rstn		(cpu_rstn),
		.instr_dec		(instr_dec),
		.csr_addr		(csr_addr),
		.mcsr_rd		(mcsr_rd),
		.mcsr_wr		(mcsr_wr),
		.valid_mcsr_rd		(valid_mcsr_rd),
		.valid_mcsr_wr		(valid_mcsr_wr),
		.mcsr_set		(mcsr_set),
		.mcsr_clr		(mcsr_clr),
		.write_data		(write_data),
		.read_data		(read_data),
		.meip			(meip),
		.mtip			(mtip),
		.mepc			(mepc),
		.mcause			(mcause),
		.mtval			(mtval),
		.valid_interrupt	(valid_interrupt),
		.mret			(mret),
		.mepc_sel		(mepc_sel),
		.mcause_sel		(mcause_sel),
		.mtval_sel		(mtval_sel),
		.csr_illegal_access	(csr_illegal_access),
		.illegal_instr		(illegal_instr),
		.meie			(meie),
		.mtie			(mtie),
		.mstatus_mie		(mstatus_mie),
		.mtvec_mode		(mtvec_mode),
		.mtvec_base		(mtvec_base),
		.dtcm_en		(dtcm_en),
		.dtcm_start_addr	(dtcm_start_addr)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
	end

	// hard stop if the tests hang
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired, run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
				   input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp,
				 $time);
		end
	endtask

	// set beats clear, plain write otherwise
	function automatic logic [31:0] update_word(input logic [31:0] old_w,
						    input logic [31:0] wd, input logic set,
						    input logic clr, input logic [31:0] mask);
		logic [31:0] nw;
		case ({set, clr})
			2'b00:		nw = wd;
			2'b01:		nw = old_w & ~wd;
			default:	nw = old_w | wd;
		endcase
		return nw & mask;	// only implemented bits kept
	endfunction

	task automatic model_reset();
		m_misa = {6'h0, `MCSR_MISA_RESET};
		m_mstatus = 32'h0;
		m_mie = 32'h0000_0880;		// meie and mtie on
		m_mtvec = `MCSR_VECTOR_ENTRY;
		m_tcm = 32'h1;
		m_dtcm = `MCSR_DTCM_START;
		m_int_active = 1'b0;
	endtask

	task automatic model_write(input csr_addr_t addr, input logic [31:0] wd,
				   input logic set, input logic clr);
		case (addr)
			`MISA:			m_misa = update_word(m_misa, wd, set, clr, 32'h03ff_ffff);
			`MSTATUS:		m_mstatus = update_word(m_mstatus, wd, set, clr, 32'h88);
			`MIE:			m_mie = update_word(m_mie, wd, set, clr, 32'h880);
			`MTVEC:			m_mtvec = update_word(m_mtvec, wd, set, clr, '1);
			`TCM_CTRL:		m_tcm = update_word(m_tcm, wd, set, clr, 32'h1);
			`DTCM_START_ADDR:	m_dtcm = update_word(m_dtcm, wd, set, clr, '1);
			default:		;	// read-only or unmapped
		endcase
	endtask

	function automatic logic [31:0] expected_read(input csr_addr_t addr);
		case (addr)
			`MIMPID:		return `MCSR_MIMPID_VALUE;
			`MISA:			return 32'h4000_0000 | m_misa;	// mxl = 1
			`MSTATUS:		return m_mstatus;
			`MIE:			return m_mie;
			`MTVEC:			return m_mtvec;
			`MEPC:			return mepc;
			`MCAUSE:		return mcause;
			`MTVAL:			return mtval;
			`MIP:			return (32'(meip) << 11) | (32'(mtip) << 7);
			`TCM_CTRL:		return m_tcm;
			`DTCM_START_ADDR:	return m_dtcm;
			default:		return 32'h0;	// vendor, arch, hart ids
		endcase
	endfunction

	function automatic csr_addr_t impl_addr(input int idx);
		case (idx)
			0:		return `MVENDORID;
			1:		return `MARCHID;
			2:		return `MIMPID;
			3:		return `MHARTID;
			4:		return `MSTATUS;
			5:		return `MISA;
			6:		return `MIE;
			7:		return `MTVEC;
			8:		return `MEPC;
			9:		return `MCAUSE;
			10:		return `MTVAL;
			11:		return `MIP;
			12:		return `TCM_CTRL;
			default:	return `DTCM_START_ADDR;
		endcase
	endfunction

	function automatic csr_addr_t writable_addr(input int idx);
		case (idx)
			0:		return `MISA;
			1:		return `MIE;
			2:		return `MTVEC;
			3:		return `TCM_CTRL;
			default:	return `DTCM_START_ADDR;
		endcase
	endfunction

	task automatic clear_inputs();
		mcsr_rd = 1'b0;
		mcsr_wr = 1'b0;
		valid_mcsr_rd = 1'b0;
		valid_mcsr_wr = 1'b0;
		mcsr_set = 1'b0;
		mcsr_clr = 1'b0;
		valid_interrupt = 1'b0;
		mret = 1'b0;
	endtask

	// one decode cycle, outputs sampled mid low phase
	task automatic drive_access(input csr_addr_t addr, input logic rd, input logic wr,
				    input logic set, input logic clr, input csr_data_t wd);
		@(negedge cpu_clk);
		clear_inputs();
		csr_addr = addr;
		mcsr_rd = rd;
		valid_mcsr_rd = rd;
		mcsr_wr = wr;
		valid_mcsr_wr = wr;
		mcsr_set = set;
		mcsr_clr = clr;
		write_data = wd;
		instr_dec = $random(seed);	// any encoding, only echoed back
		#2;
	endtask

	task automatic read_and_check(input csr_addr_t addr);
		drive_access(addr, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0);
		check_value("read_data", read_data, expected_read(addr));
		check_value("csr_illegal_access", 32'(csr_illegal_access), 32'h0);
		check_value("illegal_instr", illegal_instr, 32'h0);
	endtask

	// commit lands on the next rising edge
	task automatic write_csr(input csr_addr_t addr, input csr_data_t wd, input logic set,
				 input logic clr);
		drive_access(addr, 1'b0, 1'b1, set, clr, wd);
		check_value("csr_illegal_access", 32'(csr_illegal_access), 32'h0);
		check_value("illegal_instr", illegal_instr, 32'h0);
		check_value("read_data", read_data, 32'h0);	// no read strobe
		model_write(addr, wd, set, clr);
	endtask

	task automatic illegal_check(input csr_addr_t addr, input logic rd, input logic wr);
		drive_access(addr, rd, wr, 1'b0, 1'b0, $random(seed));
		check_value("csr_illegal_access", 32'(csr_illegal_access), 32'h1);
		check_value("illegal_instr", illegal_instr, instr_dec);
		check_value("read_data", read_data, 32'h0);
	endtask

	task automatic pulse_trap(input logic intr, input logic ret);
		@(negedge cpu_clk);
		clear_inputs();
		valid_interrupt = intr;
		mret = ret;
		if (ret && m_int_active)
		begin
			m_mstatus = {24'h0, 1'b1, 3'h0, m_mstatus[7], 3'h0};	// mie from mpie
		end
		else if (intr)
		begin
			m_mstatus = {24'h0, m_mstatus[3], 7'h0};	// mpie from mie
		end
		if (ret)
		begin
			m_int_active = 1'b0;
		end
		else if (intr)
		begin
			m_int_active = 1'b1;
		end
	endtask

	task automatic check_outputs();
		check_value("meie", 32'(meie), 32'(m_mie[11]));
		check_value("mtie", 32'(mtie), 32'(m_mie[7]));
		check_value("mstatus_mie", 32'(mstatus_mie), 32'(m_mstatus[3]));
		check_value("mtvec_mode", 32'(mtvec_mode), 32'(m_mtvec[1:0]));
		check_value("mtvec_base", mtvec_base, {m_mtvec[31:2], 2'b00});
		check_value("mtvec_base[1:0]", 32'(mtvec_base[1:0]), 32'h0);
		check_value("dtcm_en", 32'(dtcm_en), 32'(m_tcm[0]));
		check_value("dtcm_start_addr", dtcm_start_addr, m_dtcm);
	endtask

	task automatic test_reset();
		for (int i = 0; i < `MCSR_N; i++)
		begin
			read_and_check(impl_addr(i));
		end
		check_outputs();
		drive_access(`MIMPID, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);	// idle, nonzero reg
		check_value("read_data", read_data, 32'h0);
	endtask

	// mode bit 0 set, bit 1 clr, both means set
	task automatic test_write_modes();
		csr_addr_t	addr;
		csr_data_t	wd;
		for (int r = 0; r < 5; r++)
		begin
			addr = writable_addr(r);
			for (int m = 0; m < 4; m++)
			begin
				for (int n = 0; n < WR_ITER; n++)
				begin
					wd = $random(seed);
					write_csr(addr, wd, m[0], m[1]);
					read_and_check(addr);
					check_outputs();
				end
			end
		end
	endtask

	task automatic test_illegal();
		illegal_check(12'h105, 1'b1, 1'b0);	// old stvec slot
		illegal_check(12'h180, 1'b0, 1'b1);	// old satp slot
		illegal_check(`MVENDORID, 1'b0, 1'b1);
		illegal_check(`MHARTID, 1'b0, 1'b1);
		for (int i = 0; i < `MCSR_N; i++)
		begin
			read_and_check(impl_addr(i));
		end
		check_outputs();
	endtask

	task automatic test_interrupt();
		write_csr(`MSTATUS, 32'h8, 1'b1, 1'b0);	// set mie
		read_and_check(`MSTATUS);
		pulse_trap(1'b1, 1'b0);
		read_and_check(`MSTATUS);		// mie 0, mpie 1
		check_outputs();
		pulse_trap(1'b0, 1'b1);
		read_and_check(`MSTATUS);		// both back to 1
		check_outputs();
		write_csr(`MSTATUS, 32'h8, 1'b0, 1'b1);	// clear mie
		read_and_check(`MSTATUS);
		pulse_trap(1'b0, 1'b1);		// stray mret
		read_and_check(`MSTATUS);
		check_outputs();
	endtask

	task automatic test_trap_inputs();
		for (int n = 0; n < 4; n++)
		begin
			@(negedge cpu_clk);
			meip = n[0];		// every pending pair
			mtip = n[1];
			mepc = $random(seed);
			mcause = $random(seed);
			mtval = $random(seed);
			read_and_check(`MEPC);
			read_and_check(`MCAUSE);
			read_and_check(`MTVAL);
			read_and_check(`MIP);
		end
		// selects are raw address hits
		for (int i = 0; i < `MCSR_N; i++)
		begin
			drive_access(impl_addr(i), 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
			check_value("mepc_sel", 32'(mepc_sel), 32'(impl_addr(i) == `MEPC));
			check_value("mcause_sel", 32'(mcause_sel), 32'(impl_addr(i) == `MCAUSE));
			check_value("mtval_sel", 32'(mtval_sel), 32'(impl_addr(i) == `MTVAL));
		end
	endtask

	initial
	begin
		seed = 32'h0245be07;
		errors = 0;
		checks = 0;
		clear_inputs();
		cpu_rstn = 1'b0;
		instr_dec = '0;
		csr_addr = '0;
		write_data = '0;
		meip = 1'b0;
		mtip = 1'b0;
		mepc = '0;
		mcause = '0;
		mtval = '0;
		model_reset();
		repeat (RST_CYCLES) @(negedge cpu_clk);
		cpu_rstn = 1'b1;

		test_reset();
		test_write_modes();
		test_illegal();
		test_interrupt();
		test_trap_inputs();

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/mcsr_pkg.sv
mcsr/csr_decode.sv
mcsr/mstatus_trap.sv
mcsr/csr_config_regs.sv
mcsr/csr_read_mux.sv
mcsr/mcsr.sv
verification/mcsr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mcsr testbench with verilator

cd "$(dirname "$0")" || exit 1

top=mcsr_tb
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
	-f vlog.f --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTS PASSED" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
